/* memory_bus.f */
+incdir+tests
hdl/memory_bus_pkg.sv
hdl/sram_port_if.sv
hdl/bank_steer.sv
hdl/sram_bank.sv
hdl/read_merge.sv
hdl/memory_bus.sv
tests/memory_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory_bus testbench with Verilator and runs it.
# The run counts as passed only when its output holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f memory_bus.f \
	--top-module memory_bus_tb -o memory_bus_sim \
	|| { echo "Verilator build failed."; exit 1; }

sim_out="$(./obj_dir/memory_bus_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "NO ERRORS" && echo "Simulation passed." \
	|| { echo "Simulation failed."; exit 1; }

/* tests/memory_bus_model.svh */
// Byte model of the 32 KiB SRAM window, the LCG and the expected-value functions.
// Offsets come from address bits 14:2, so the even-row wrap is a plain array wrap.
// Bytes never written are unknown and masked out of the compare.

`ifndef MEMORY_BUS_MODEL_SVH
`define MEMORY_BUS_MODEL_SVH

localparam int model_bytes = 32768; // Both banks together.

logic [7:0]  model_mem [model_bytes];   // Expected SRAM contents.
bit          model_known [model_bytes]; // Byte written at least once.
logic [31:0] lcg_state = 32'd3464;      // Seed.

// Plain 32-bit LCG.
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Window 0x8000_0000 to 0x8FFF_FFFF, upper word zero.
function automatic bit in_window(input logic [63:0] addr);
	return addr[63:28] == 36'h8;
endfunction

// Fill data, every address bit takes part.
function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
	return (addr * 64'h9E37_79B9_7F4A_7C15) ^ {addr[31:0], addr[63:32]};
endfunction

// One request. Reads the old 8 bytes, then applies the strobed write.
function automatic void model_access(input logic [63:0] addr, input logic [63:0] wdata,
		input logic [7:0] strb, input logic wen,
		output logic [63:0] exp, output logic [63:0] mask);
	logic [14:0] off;
	logic [14:0] idx;
	exp  = '0;
	mask = '1; // Misses compare all bytes against zero.
	if (in_window(addr)) begin
		off = {addr[14:2], 2'b00};
		for (int b = 0; b < 8; b++) begin
			idx = off + 15'(b); // Wraps at the top of the array.
			if (model_known[idx]) begin
				exp[b*8 +: 8] = model_mem[idx];
			end else begin
				mask[b*8 +: 8] = 8'h00; // Never written.
			end
		end
		for (int b = 0; b < 8; b++) begin
			idx = off + 15'(b);
			if (wen && strb[b]) begin
				model_mem[idx]   = wdata[b*8 +: 8];
				model_known[idx] = 1'b1;
			end
		end
	end
endfunction

`endif

/* tests/memory_bus_tb.sv */
// Testbench for memory_bus: fills the window, then directed and random requests.
// Every response is compared with the byte model, in request order.
// Inputs change 2 ns after the rising edge; outputs are sampled on the falling edge.

`timescale 1ns/1ps

module memory_bus_tb;

	`include "memory_bus_model.svh"

	logic        CLK = 1'b0;
	logic        rst;
	logic        mem_req_valid;
	logic [63:0] mem_addr;
	logic [63:0] mem_data_w;
	logic [7:0]  mem_wstrb;
	logic        mem_wen;
	logic [63:0] mem_data_r;
	logic        mem_rsp_valid;

	logic [63:0] exp_q [$];  // Expected data, oldest first.
	logic [63:0] mask_q [$]; // Known bytes per response.
	logic [63:0] addr_q [$]; // Request address, for error lines.
	logic [63:0] cur_exp;
	logic [63:0] cur_mask;
	logic [63:0] cur_addr;
	logic        req_at_edge = 1'b0; // Request seen at the last rising edge.

	memory_bus i_memory_bus (
		.CLK           (CLK),
		.rst           (rst),
		.mem_req_valid (mem_req_valid),
		.mem_addr      (mem_addr),
		.mem_data_w    (mem_data_w),
		.mem_wstrb     (mem_wstrb),
		.mem_wen       (mem_wen),
		.mem_data_r    (mem_data_r),
		.mem_rsp_valid (mem_rsp_valid)
	);

	initial begin
		forever #10 CLK = ~CLK; // 20 ns period.
	end

	// Prints the cause and the fail message, then stops.
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on first error.");
	endtask

	// One request for one cycle, expectation queued first.
	task automatic issue(input logic [63:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input logic wen);
		logic [63:0] exp;
		logic [63:0] mask;
		model_access(addr, data, strb, wen, exp, mask);
		exp_q.push_back(exp);
		mask_q.push_back(mask);
		addr_q.push_back(addr);
		mem_req_valid = 1'b1;
		mem_addr      = addr;
		mem_data_w    = data;
		mem_wstrb     = strb;
		mem_wen       = wen;
		@(posedge CLK);
		#2;
		mem_req_valid = 1'b0;
		mem_wen       = 1'b0;
		mem_wstrb     = '0;
	endtask

	task automatic idle_cycle();
		@(posedge CLK);
		#2;
	endtask

	// Bounded wait until every queued response is back.
	task automatic drain_responses();
		for (int i = 0; i < 20 && exp_q.size() != 0; i++) begin
			@(negedge CLK);
		end
	endtask

	always @(posedge CLK) begin
		req_at_edge <= mem_req_valid;
	end

	// Valid must follow each request by one cycle, data must match the model.
	always @(negedge CLK) begin
		assert (mem_rsp_valid === req_at_edge)
			else fail_now($sformatf("Response valid was %b at %0t ns, a request was %0s.",
				mem_rsp_valid, $time, req_at_edge ? "taken" : "not taken"));
		if (mem_rsp_valid === 1'b1) begin
			assert (exp_q.size() != 0)
				else fail_now($sformatf("Response at %0t ns with no request waiting.", $time));
			cur_exp  = exp_q.pop_front();
			cur_mask = mask_q.pop_front();
			cur_addr = addr_q.pop_front();
			assert ((mem_data_r & cur_mask) === (cur_exp & cur_mask))
				else fail_now($sformatf("Mismatch at %0t ns: addr 0x%h expected 0x%h got 0x%h",
					$time, cur_addr, cur_exp & cur_mask, mem_data_r));
		end
	end

	initial begin
		logic [63:0] a;
		logic [63:0] d;
		logic [31:0] r32;
		logic [31:0] r2;
		rst           = 1'b1;
		mem_req_valid = 1'b0;
		mem_addr      = '0;
		mem_data_w    = '0;
		mem_wstrb     = '0;
		mem_wen       = 1'b0;
		repeat (8) @(posedge CLK);
		#2 rst = 1'b0;
		idle_cycle(); // Still no response expected here.

		// Fill every row, first reads are unknown and masked.
		for (int r = 0; r < 4096; r++) begin
			a = {32'h0, 4'h8, 13'h0, r[11:0], 3'b000};
			issue(a, fill_pattern(a), 8'hFF, 1'b1);
		end

		// Aligned write and read back.
		issue(64'h8000_1238, 64'h0123_4567_89AB_CDEF, 8'hFF, 1'b1);
		issue(64'h8000_1238, 64'h0, 8'h00, 1'b0);

		// Bit 2 set, halves cross banks.
		issue(64'h8000_2344, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 1'b1);
		issue(64'h8000_2344, 64'h0, 8'h00, 1'b0);
		issue(64'h8FFF_FFFC, 64'h1122_3344_5566_7788, 8'hFF, 1'b1); // Even row wraps.
		issue(64'h8FFF_FFFC, 64'h0, 8'h00, 1'b0);
		issue(64'h8000_0000, 64'h0, 8'h00, 1'b0); // Row 0 holds the wrapped half.

		// Partial strobes, then strobes without write enable.
		issue(64'h8000_3000, 64'hA1A2_A3A4_A5A6_A7A8, 8'b0101_1010, 1'b1);
		issue(64'h8000_3000, 64'h0, 8'h00, 1'b0);
		issue(64'h8000_3000, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 1'b0);
		issue(64'h8000_3000, 64'h0, 8'h00, 1'b0);

		// Outside the window, aliased offset must stay.
		issue(64'h9000_0000, 64'h5555_AAAA_5555_AAAA, 8'hFF, 1'b1);
		issue(64'h0000_0000, 64'h3333_CCCC_3333_CCCC, 8'hFF, 1'b1);
		issue(64'h8000_0000, 64'h0, 8'h00, 1'b0);
		drain_responses();

		// Random back-to-back traffic with gaps.
		for (int n = 0; n < 300; n++) begin
			r32 = lcg_next();
			r2  = lcg_next();
			d[63:32] = lcg_next();
			d[31:0]  = lcg_next();
			if (r32[31:30] != 2'b00) begin
				a = {32'h0, 4'h8, r2[31:6], 2'b00};
			end else begin
				a = {32'h0, (r2[31:28] == 4'h8) ? 4'h9 : r2[31:28], r2[27:2], 2'b00};
			end
			issue(a, d, r32[23:16], r32[29]);
			if (r32[27:26] == 2'b00) begin
				idle_cycle(); // Gap in mem_req_valid.
			end
		end
		drain_responses();

		if (exp_q.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_now($sformatf("%0d responses never arrived.", exp_q.size()));
		end
	end

endmodule

/* hdl/memory_bus.sv */
// Doubleword memory port of the core, backed by two 32-bit SRAM banks.
// Window 0x8000_0000 to 0x8FFF_FFFF only; other addresses read zero, write nothing.
// Response one cycle after each request, no ready, consumer must take it.
// A 4-byte aligned access still moves 8 bytes in one cycle.

`timescale 1ns/1ps

module memory_bus (
	input  logic                               CLK,
	input  logic                               rst,
	input  logic                               mem_req_valid,
	input  logic [memory_bus_pkg::addr_w-1:0]  mem_addr,
	input  logic [memory_bus_pkg::dword_w-1:0] mem_data_w,
	input  logic [memory_bus_pkg::strb_w-1:0]  mem_wstrb,
	input  logic                               mem_wen,
	output logic [memory_bus_pkg::dword_w-1:0] mem_data_r,
	output logic                               mem_rsp_valid
);

	logic hit;  // Valid request inside the window.
	logic swap; // Low half lives in the odd bank.

	// Per-bank request bundles.
	sram_port_if port_eve ();
	sram_port_if port_odd ();

	// Region decode and lane steering.
	bank_steer i_steer (
		.mem_req_valid (mem_req_valid),
		.mem_addr      (mem_addr),
		.mem_data_w    (mem_data_w),
		.mem_wstrb     (mem_wstrb),
		.mem_wen       (mem_wen),
		.port_eve      (port_eve.ctrl),
		.port_odd      (port_odd.ctrl),
		.hit           (hit),
		.swap          (swap)
	);

	// Even words, addresses with bit 2 clear.
	sram_bank i_bank_eve (
		.CLK  (CLK),
		.port (port_eve.mem)
	);

	// Odd words.
	sram_bank i_bank_odd (
		.CLK  (CLK),
		.port (port_odd.mem)
	);

	// Response side.
	read_merge i_merge (
		.CLK           (CLK),
		.rst           (rst),
		.mem_req_valid (mem_req_valid),
		.hit           (hit),
		.swap          (swap),
		.port_eve      (port_eve.rd),
		.port_odd      (port_odd.rd),
		.mem_data_r    (mem_data_r),
		.mem_rsp_valid (mem_rsp_valid)
	);

endmodule

/* hdl/read_merge.sv */
// Turns the two bank read words back into one doubleword response.
// Response valid follows every request one cycle later, with no back-pressure.
// Misses return zero; the banks are not touched for them.

`timescale 1ns/1ps

module read_merge (
	input  logic                               CLK,
	input  logic                               rst,
	input  logic                               mem_req_valid,
	input  logic                               hit,
	input  logic                               swap,
	sram_port_if.rd                            port_eve,
	sram_port_if.rd                            port_odd,
	output logic [memory_bus_pkg::dword_w-1:0] mem_data_r,
	output logic                               mem_rsp_valid
);
	import memory_bus_pkg::*;

	logic   hit_q;  // Request in flight was in the window.
	logic   swap_q; // Request in flight had bit 2 set.
	dword_u rdata;  // Assembled response.

	// Request attributes, captured only when a request is taken.
	always_ff @(posedge CLK) begin
		if (rst) begin
			hit_q  <= 1'b0;
			swap_q <= 1'b0;
		end else if (mem_req_valid) begin
			hit_q  <= hit;
			swap_q <= swap;
		end
	end

	// Handshake, one cycle behind the request.
	always_ff @(posedge CLK) begin
		if (rst) begin
			mem_rsp_valid <= 1'b0;
		end else begin
			mem_rsp_valid <= mem_req_valid; // Every request answers.
		end
	end

	// Undo the lane crossing done on the write side.
	always_comb begin
		if (swap_q) begin
			rdata.lanes.lo = port_odd.data_r;
			rdata.lanes.hi = port_eve.data_r;
		end else begin
			rdata.lanes.lo = port_eve.data_r;
			rdata.lanes.hi = port_odd.data_r;
		end
		if (!hit_q) begin
			rdata.whole = '0; // Outside the window.
		end
	end

	assign mem_data_r = rdata.whole;

	// A window hit from the steer only comes with a taken request.
	a_hit_needs_req: assert property (
		@(posedge CLK) disable iff (rst)
		hit |-> mem_req_valid
	) else $error("Window hit flagged without a request.");

endmodule

/* hdl/sram_bank.sv */
// One 4096 x 32 bank with byte strobes and a registered, read-first output.
// Contents power up unknown; nothing clears them.
// data_r holds its last value in cycles without an enable.

`timescale 1ns/1ps

module sram_bank (
	input  logic     CLK,
	sram_port_if.mem port
);
	import memory_bus_pkg::*;

	logic [lane_w-1:0] mem [sram_depth]; // Storage array.
	logic [lane_w-1:0] rd_word;          // Output register.

	// Read and write share the edge.
	// Nonblocking update leaves the old word on data_r.
	always_ff @(posedge CLK) begin
		if (port.en) begin
			rd_word <= mem[port.addr]; // Old contents.
			for (int b = 0; b < lane_strb_w; b++) begin
				if (port.wstrb[b]) begin
					mem[port.addr][b*8 +: 8] <= port.data_w[b*8 +: 8]; // Byte lane b.
				end
			end
		end
	end

	assign port.data_r = rd_word;

	// Strobes must be known whenever the bank is enabled.
	// An X here would silently corrupt bytes in the array.
	a_wstrb_known: assert property (
		@(posedge CLK) port.en |-> !$isunknown(port.wstrb)
	) else $error("Bank enabled with unknown strobes.");

	// A byte write never arrives without the row enable.
	a_strb_needs_en: assert property (
		@(posedge CLK) (port.wstrb != '0) |-> port.en
	) else $error("Bank strobes 0x%h without enable.", port.wstrb);

	// Row index must be known too.
	a_addr_known: assert property (
		@(posedge CLK) port.en |-> !$isunknown(port.addr)
	) else $error("Bank enabled with unknown row.");

endmodule

/* hdl/bank_steer.sv */
// Splits one doubleword request over the even and odd banks, purely combinational.
// Only 4-byte alignment is required; bit 2 set means the low half sits in the odd bank.
// Out-of-window requests enable neither bank, so they never write.

`timescale 1ns/1ps

module bank_steer (
	input  logic                                  mem_req_valid,
	input  logic [memory_bus_pkg::addr_w-1:0]     mem_addr,
	input  logic [memory_bus_pkg::dword_w-1:0]    mem_data_w,
	input  logic [memory_bus_pkg::strb_w-1:0]     mem_wstrb,
	input  logic                                  mem_wen,
	sram_port_if.ctrl                             port_eve,
	sram_port_if.ctrl                             port_odd,
	output logic                                  hit,
	output logic                                  swap
);
	import memory_bus_pkg::*;

	logic                   in_window; // Address inside the SRAM region.
	logic                   wr;        // Strobes allowed through.
	logic [sram_aw-1:0]     row;       // Odd bank row, also even row without swap.
	logic [sram_aw-1:0]     row_eve;   // Even bank row after wrap.
	dword_u                 wdata;     // Write data seen as two lanes.
	logic [lane_strb_w-1:0] strb_lo;   // Strobes of the low lane.
	logic [lane_strb_w-1:0] strb_hi;   // Strobes of the high lane.
	logic [lane_strb_w-1:0] strb_eve;
	logic [lane_strb_w-1:0] strb_odd;

	// Region decode, same masking as the memory map.
	assign in_window = (mem_addr | sram_region_mask) == sram_region_tag;
	assign hit       = mem_req_valid & in_window;
	assign swap      = mem_addr[2]; // Low half in odd bank.

	assign wr = hit & mem_wen;

	// Doubleword row, bits 14:3.
	assign row = mem_addr[3 +: sram_aw];

	// Crossed access spans two rows.
	// The even word follows the odd one, so it is one row up.
	// Plain width truncation gives the wrap at the top row.
	assign row_eve = swap ? row + 1'b1 : row;

	assign wdata.whole = mem_data_w;

	// Byte enables per lane, dropped for reads and misses.
	assign strb_lo = wr ? mem_wstrb[lane_strb_w-1:0] : '0;
	assign strb_hi = wr ? mem_wstrb[strb_w-1:lane_strb_w] : '0;

	// Lane crossing.
	assign strb_eve = swap ? strb_hi : strb_lo;
	assign strb_odd = swap ? strb_lo : strb_hi;

	always_comb begin
		// Even bank.
		port_eve.en     = hit;
		port_eve.addr   = row_eve;
		port_eve.data_w = swap ? wdata.lanes.hi : wdata.lanes.lo;
		port_eve.wstrb  = strb_eve;

		// Odd bank.
		port_odd.en     = hit;
		port_odd.addr   = row;
		port_odd.data_w = swap ? wdata.lanes.lo : wdata.lanes.hi;
		port_odd.wstrb  = strb_odd;
	end

endmodule

/* hdl/sram_port_if.sv */
// Request and read-data bundle for one 32-bit SRAM bank.
// No clock inside; the bank samples it on its own clock edge.

`timescale 1ns/1ps

interface sram_port_if;
	import memory_bus_pkg::*;

	logic                   en;     // Row access this cycle.
	logic [sram_aw-1:0]     addr;   // Row index.
	logic [lane_w-1:0]      data_w; // Write word.
	logic [lane_strb_w-1:0] wstrb;  // Byte write enables, zero for reads.
	logic [lane_w-1:0]      data_r; // Registered read word.

	// Steering side.
	modport ctrl (
		output en,
		output addr,
		output data_w,
		output wstrb
	);

	// Bank itself.
	modport mem (
		input  en,
		input  addr,
		input  data_w,
		input  wstrb,
		output data_r
	);

	// Read merger only looks at the data.
	modport rd (
		input data_r
	);

endinterface

/* hdl/memory_bus_pkg.sv */
// Memory map and bank geometry for the doubleword SRAM subsystem.
// Only the 0x8xxx_xxxx window is backed; 32 KiB split over two 32-bit banks.
// Row count is fixed here. Changing sram_aw resizes both banks together.

package memory_bus_pkg;

	// Bus side widths.
	localparam int addr_w  = 64; // Full core address.
	localparam int dword_w = 64; // One bus doubleword.
	localparam int strb_w  = dword_w / 8; // Byte strobes per doubleword.

	// Bank geometry.
	localparam int sram_aw     = 12; // Row address bits per bank.
	localparam int sram_depth  = 1 << sram_aw; // 4096 rows.
	localparam int lane_w      = 32; // One bank word.
	localparam int lane_strb_w = lane_w / 8; // Byte strobes per bank word.

	// Region decode.
	// Bits under the mask are ignored, the rest must match the tag.
	localparam logic [addr_w-1:0] sram_region_mask = 64'h0000_0000_0FFF_FFFF;
	localparam logic [addr_w-1:0] sram_region_tag  = 64'h0000_0000_8FFF_FFFF;

	// Lower word of the pair is lo, on bits 31:0.
	typedef struct packed {
		logic [lane_w-1:0] hi;
		logic [lane_w-1:0] lo;
	} lane_pair_t;

	// Same 64 bits, seen as one word or as two bank lanes.
	typedef union packed {
		logic [dword_w-1:0] whole;
		lane_pair_t         lanes;
	} dword_u;

	// Sizes must agree or the union views drift apart.
	// Caught at elaboration by the struct and vector width mismatch.

endpackage
